// ==== dv/kbd_tests.txt ====
# test <name> <host ready: 0 always, 1 random, 2 low until sent> <expected overflow_o>
# send <items>: hex, low byte is the frame data, top digit 0 good, 1 bad parity, 2 low stop
# expect <events>: hex, bit 9 extended, bit 8 released, low byte the code

test make_code 0 0
send 01C
expect 01C

test release_and_extended 0 0
send 0F0 01C 0E0 0F0 074 0E0 075 0E0 0F0 075
expect 11C 374 275 375

test bad_frames 0 0
send 11C 032 221 1F0 023 2E0 034
expect 032 023 034

test random_ready 1 0
send 01C 0F0 01C 0E0 06B 0E0 0F0 06B 029 0F0 029 05A 0F0 05A 0E0 011
expect 01C 11C 26B 36B 029 129 05A 15A 211

test overflow 2 1
send 015 016 01E 026 025 02E 036 03D 03E 046
expect 015 016 01E 026 025 02E 036 03D

// ==== tb.f ====
design/common.sv
design/ps2_rx.sv
design/scancode_decoder.sv
design/key_event_fifo.sv
design/kbd_ctrl.sv
dv/kbd_assert.sv
dv/kbd_checker.sv
dv/kbd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the PS/2 keyboard controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module kbd_tb \
    -f tb.f -o kbd_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/kbd_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
exit 0

// ==== dv/kbd_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module kbd_tb;

    import common::*;

    localparam int HALF_BIT_CYCLES  = 5;
    localparam int FRAME_GAP_CYCLES = 20;
    localparam int DONE_TIMEOUT     = 5000;

    logic       clk;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic       evt_ready = 1'b0;
    key_event_t evt;
    logic       evt_valid;
    logic       overflow;

    // sequencing between driver and checker
    int          host_mode;
    logic        test_start;
    logic        frames_done;
    logic        test_done;
    logic        stalled;
    logic        checks_finished;
    logic        run_aborted;
    int          error_count;
    logic [11:0] frame_q[$];

    kbd_ctrl kbd_ctrl_i (
        .clk_i       (clk),
        .reset_i     (reset),
        .ps2_clk_i   (ps2_clk),
        .ps2_data_i  (ps2_data),
        .evt_o       (evt),
        .evt_valid_o (evt_valid),
        .evt_ready_i (evt_ready),
        .overflow_o  (overflow)
    );

    kbd_checker kbd_checker_i (
        .clk_i         (clk),
        .evt_i         (evt),
        .evt_valid_i   (evt_valid),
        .evt_ready_i   (evt_ready),
        .overflow_i    (overflow),
        .start_i       (test_start),
        .frames_done_i (frames_done),
        .done_o        (test_done),
        .stalled_o     (stalled),
        .finished_o    (checks_finished),
        .error_count_o (error_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // mode 0 keeps ready high and mode 1 toggles it at random
    // mode 2 holds it low until every frame is sent
    initial begin
        void'($urandom(48));
        forever begin
            @(negedge clk);
            case (host_mode)
                0:       evt_ready <= 1'b1;
                1:       evt_ready <= 1'($urandom % 2);
                default: evt_ready <= frames_done;
            endcase
        end
    end

    function automatic string word_at(string line, int idx);
        int    pos;
        int    first;
        int    count;
        string found;
        pos   = 0;
        count = 0;
        found = "";
        while (pos < line.len()) begin
            if (line.getc(pos) <= 8'd32) begin
                pos++;
            end else begin
                first = pos;
                while (pos < line.len() && line.getc(pos) > 8'd32) begin
                    pos++;
                end
                if (count == idx) begin
                    found = line.substr(first, pos - 1);
                end
                count++;
            end
        end
        return found;
    endfunction

    // data changes while the ps2 clock is high
    task automatic send_bit(logic value);
        @(negedge clk);
        ps2_data <= value;
        repeat (HALF_BIT_CYCLES) @(negedge clk);
        ps2_clk <= 1'b0;
        repeat (HALF_BIT_CYCLES) @(negedge clk);
        ps2_clk <= 1'b1;
    endtask

    // item[11:8] picks the frame kind and item[7:0] is the data byte
    task automatic send_frame(logic [11:0] item);
        int          i;
        byte_t       data;
        logic        parity;
        logic        stop;
        logic [10:0] bits;
        data   = item[7:0];
        parity = ~^data;
        stop   = 1'b1;
        if (item[11:8] == 4'h1) begin
            parity = ~parity;
        end
        if (item[11:8] == 4'h2) begin
            stop = 1'b0;
        end
        bits = {stop, parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            send_bit(bits[i]);
        end
        ps2_data <= 1'b1;
        repeat (FRAME_GAP_CYCLES) @(negedge clk);
    endtask

    task automatic run_test(string name, int mode);
        int waited;
        host_mode <= mode;
        @(negedge clk);
        test_start <= 1'b1;
        @(negedge clk);
        test_start <= 1'b0;
        foreach (frame_q[i]) begin
            send_frame(frame_q[i]);
        end
        frames_done <= 1'b1;
        waited = 0;
        while (!test_done && !stalled && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (stalled || !test_done) begin
            $display("test %s did not finish in time", name);
            run_aborted = 1'b1;
        end else begin
            frames_done <= 1'b0;
        end
    endtask

    initial begin
        int    fd;
        int    idx;
        int    mode;
        int    waited;
        string line;
        string key;
        string tok;
        string name;
        reset       = 1'b1;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        host_mode   = 0;
        test_start  = 1'b0;
        frames_done = 1'b0;
        run_aborted = 1'b0;
        mode        = 0;
        name        = "";
        repeat (5) @(negedge clk);
        reset <= 1'b0;
        fd = $fopen("dv/kbd_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/kbd_tests.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            while (!run_aborted && $fgets(line, fd) != 0) begin
                key = word_at(line, 0);
                if (key == "test") begin
                    name = word_at(line, 1);
                    tok  = word_at(line, 2);
                    mode = tok.atoi();
                end else if (key == "send") begin
                    frame_q.delete();
                    idx = 1;
                    tok = word_at(line, idx);
                    while (tok != "") begin
                        frame_q.push_back(12'(tok.atohex()));
                        idx++;
                        tok = word_at(line, idx);
                    end
                    run_test(name, mode);
                end
            end
            $fclose(fd);
            if (!run_aborted) begin
                waited = 0;
                while (!checks_finished && waited < DONE_TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (!checks_finished) begin
                    $display("checker never reported its totals");
                end
            end
            if (!run_aborted && checks_finished && error_count == 0 &&
                kbd_ctrl_i.kbd_assert_i.fail_count == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/kbd_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module kbd_checker (
    input  wire logic               clk_i,
    input  wire common::key_event_t evt_i,
    input  wire logic               evt_valid_i,
    input  wire logic               evt_ready_i,
    input  wire logic               overflow_i,
    input  wire logic               start_i,
    input  wire logic               frames_done_i,
    output logic                    done_o,
    output logic                    stalled_o,
    output logic                    finished_o,
    output int                      error_count_o
);

    import common::*;

    localparam int START_TIMEOUT = 2000;
    localparam int TEST_TIMEOUT  = 20000;

    key_event_t expected_q[$];
    string      test_name;
    logic       expected_ovf;
    int         tests_run;
    int         tests_failed;

    // n-th blank separated word of a line, empty past the end
    function automatic string word_at(string line, int idx);
        int    pos;
        int    first;
        int    count;
        string found;
        pos   = 0;
        count = 0;
        found = "";
        while (pos < line.len()) begin
            if (line.getc(pos) <= 8'd32) begin
                pos++;
            end else begin
                first = pos;
                while (pos < line.len() && line.getc(pos) > 8'd32) begin
                    pos++;
                end
                if (count == idx) begin
                    found = line.substr(first, pos - 1);
                end
                count++;
            end
        end
        return found;
    endfunction

    task automatic check_test();
        int         waited;
        int         received;
        int         test_errors;
        key_event_t expected;
        waited      = 0;
        received    = 0;
        test_errors = 0;
        while (!start_i && waited < START_TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (!start_i) begin
            $display("test %s stalled: the driver never started it", test_name);
            error_count_o++;
            stalled_o = 1'b1;
        end else begin
            waited = 0;
            // runs until every frame is sent and the queue has drained
            while (!(frames_done_i && !evt_valid_i) && waited < TEST_TIMEOUT) begin
                @(posedge clk_i);
                waited++;
                if (evt_valid_i && evt_ready_i) begin
                    if (expected_q.size() == 0) begin
                        $display("ERR test %s: extra evt_o = 0x%h", test_name, evt_i);
                        test_errors++;
                    end else begin
                        expected = expected_q.pop_front();
                        if (evt_i !== expected) begin
                            $display("ERR test %s event %0d: evt_o = 0x%h, expected 0x%h",
                                     test_name, received, evt_i, expected);
                            test_errors++;
                        end
                    end
                    received++;
                end
            end
            if (!(frames_done_i && !evt_valid_i)) begin
                $display("test %s stalled: the host port did not drain", test_name);
                error_count_o++;
                stalled_o = 1'b1;
            end else begin
                if (expected_q.size() != 0) begin
                    $display("test %s: %0d expected events never arrived",
                             test_name, expected_q.size());
                    test_errors++;
                end
                if (overflow_i !== expected_ovf) begin
                    $display("ERR test %s: overflow_o = 0x%h, expected 0x%h",
                             test_name, overflow_i, expected_ovf);
                    test_errors++;
                end
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                error_count_o += test_errors;
                $display("test %-22s %0d events, %0d errors, %s", test_name, received,
                         test_errors, (test_errors == 0) ? "ok" : "FAILED");
                done_o <= 1'b1;
                @(posedge clk_i);
                done_o <= 1'b0;
            end
        end
    endtask

    initial begin
        int    fd;
        int    idx;
        string line;
        string key;
        string tok;
        done_o        = 1'b0;
        stalled_o     = 1'b0;
        finished_o    = 1'b0;
        error_count_o = 0;
        tests_run     = 0;
        tests_failed  = 0;
        fd = $fopen("dv/kbd_tests.txt", "r");
        if (fd == 0) begin
            $display("checker cannot open dv/kbd_tests.txt");
            error_count_o = 1;
        end else begin
            while (!stalled_o && $fgets(line, fd) != 0) begin
                key = word_at(line, 0);
                if (key == "test") begin
                    test_name = word_at(line, 1);
                    tok       = word_at(line, 3);
                    expected_ovf = (tok.atoi() != 0);
                    expected_q.delete();
                end else if (key == "expect") begin
                    idx = 1;
                    tok = word_at(line, idx);
                    while (tok != "") begin
                        expected_q.push_back(key_event_t'(10'(tok.atohex())));
                        idx++;
                        tok = word_at(line, idx);
                    end
                    check_test();
                end
            end
            $fclose(fd);
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count_o);
        finished_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/kbd_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module kbd_assert (
    input wire logic               clk_i,
    input wire logic               reset_i,
    input wire common::key_event_t evt_i,
    input wire logic               evt_valid_i,
    input wire logic               evt_ready_i,
    input wire logic               overflow_i
);

    int fail_count = 0;

    // head entry holds while the host stalls
    stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (evt_valid_i && !evt_ready_i) |=> (evt_valid_i && $stable(evt_i)))
    else begin
        fail_count++;
        $error("evt_o or evt_valid_o changed while the host stalled");
    end

    reset_state: assert property (@(posedge clk_i)
        reset_i |=> (!evt_valid_i && !overflow_i))
    else begin
        fail_count++;
        $error("evt_valid_o or overflow_o high in the cycle after reset");
    end

    // overflow is sticky until reset
    overflow_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
        overflow_i |=> overflow_i)
    else begin
        fail_count++;
        $error("overflow_o fell without a reset");
    end

endmodule

bind kbd_ctrl kbd_assert kbd_assert_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .evt_i       (evt_o),
    .evt_valid_i (evt_valid_o),
    .evt_ready_i (evt_ready_i),
    .overflow_i  (overflow_o)
);

`default_nettype wire

// ==== design/kbd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module kbd_ctrl (
    input  wire logic          clk_i,
    input  wire logic          reset_i,

    // keyboard lines, not yet synchronized
    input  wire logic          ps2_clk_i,
    input  wire logic          ps2_data_i,

    // host event port
    output common::key_event_t evt_o,
    output logic               evt_valid_o,
    input  wire logic          evt_ready_i,
    output logic               overflow_o
);

    import common::*;

    byte_t      rx_data;
    logic       rx_valid;
    key_event_t dec_event;
    logic       dec_valid;

    ps2_rx ps2_rx_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .clk_ps2_async_i  (ps2_clk_i),
        .ps2_data_async_i (ps2_data_i),
        .data_o           (rx_data),
        .valid_o          (rx_valid)
    );

    scancode_decoder scancode_decoder_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rx_data_i     (rx_data),
        .rx_valid_i    (rx_valid),
        .event_o       (dec_event),
        .event_valid_o (dec_valid)
    );

    key_event_fifo key_event_fifo_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_event_i (dec_event),
        .wr_valid_i (dec_valid),
        .rd_event_o (evt_o),
        .rd_valid_o (evt_valid_o),
        .rd_ready_i (evt_ready_i),
        .overflow_o (overflow_o)
    );

endmodule

`default_nettype wire

// ==== design/key_event_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_event_fifo (
    input  wire logic               clk_i,
    input  wire logic               reset_i,

    // write side, cannot be stalled
    input  wire common::key_event_t wr_event_i,
    input  wire logic               wr_valid_i,

    // host side
    output common::key_event_t      rd_event_o,
    output logic                    rd_valid_o,
    input  wire logic               rd_ready_i,

    // sticky, events were lost
    output logic                    overflow_o
);

    import common::*;

    key_event_t                  mem_r [EVENT_FIFO_DEPTH];
    logic [EVENT_FIFO_PTR_W-1:0] wr_ptr_r;
    logic [EVENT_FIFO_PTR_W-1:0] rd_ptr_r;
    logic [EVENT_FIFO_PTR_W:0]   count_r;
    logic                        full;
    logic                        do_write;
    logic                        do_read;

    assign full     = (count_r == (EVENT_FIFO_PTR_W + 1)'(EVENT_FIFO_DEPTH));
    assign do_write = wr_valid_i && !full;
    assign do_read  = rd_valid_o && rd_ready_i;

    // head entry straight from storage
    assign rd_valid_o = (count_r != '0);
    assign rd_event_o = mem_r[rd_ptr_r];

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem_r[wr_ptr_r] <= wr_event_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            count_r    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_read) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            case ({do_write, do_read})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            if (wr_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scancode_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module scancode_decoder (
    input  wire logic          clk_i,
    input  wire logic          reset_i,

    // bytes from the receiver
    input  wire common::byte_t rx_data_i,
    input  wire logic          rx_valid_i,

    // folded key events
    output common::key_event_t event_o,
    output logic               event_valid_o
);

    import common::*;

    logic extended_r;
    logic released_r;
    logic is_extended;
    logic is_release;
    logic is_code;

    // classify the incoming byte
    assign is_extended = rx_valid_i && (rx_data_i == PREFIX_EXTENDED);
    assign is_release  = rx_valid_i && (rx_data_i == PREFIX_RELEASE);
    assign is_code     = rx_valid_i && !is_extended && !is_release;

    // pending prefix flags and the output strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            extended_r    <= 1'b0;
            released_r    <= 1'b0;
            event_valid_o <= 1'b0;
        end else begin
            event_valid_o <= is_code;
            if (is_code) begin
                // flags belong to this code only
                extended_r <= 1'b0;
                released_r <= 1'b0;
            end else begin
                if (is_extended) begin
                    extended_r <= 1'b1;
                end
                if (is_release) begin
                    released_r <= 1'b1;
                end
            end
        end
    end

    // event payload, captured with the strobe
    always_ff @(posedge clk_i) begin
        if (is_code) begin
            event_o.extended <= extended_r;
            event_o.released <= released_r;
            event_o.code     <= rx_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/ps2_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_rx (
    input  wire logic   clk_i,
    input  wire logic   reset_i,

    // raw lines from the keyboard
    input  wire logic   clk_ps2_async_i,
    input  wire logic   ps2_data_async_i,

    // received byte, one-cycle strobe
    output common::byte_t data_o,
    output logic          valid_o
);

    import common::*;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DATA   = 2'b01,
        PARITY = 2'b10,
        STOP   = 2'b11
    } rx_state_t;

    // [1:0] is the synchronizer, [2] holds the previous level for edge detect
    logic [2:0] clk_sync_r;
    logic       ps2_data_r;
    logic       falling_edge;

    rx_state_t  state_r;
    rx_state_t  state_next;
    logic [2:0] bit_cnt_r;
    logic       parity_r;
    byte_t      shift_r;
    logic       parity_ok;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clk_sync_r <= 3'b111;
            ps2_data_r <= 1'b1;
        end else begin
            clk_sync_r <= {clk_sync_r[1:0], clk_ps2_async_i};
            ps2_data_r <= ps2_data_async_i;
        end
    end

    // keyboard drives data while its clock is high, we sample on the fall
    assign falling_edge = clk_sync_r[2] && !clk_sync_r[1];

    // data bits xor parity bit must come out odd
    assign parity_ok = parity_r ^ ps2_data_r;

    always_comb begin
        state_next = state_r;
        if (falling_edge) begin
            case (state_r)
                IDLE: begin
                    // low start bit opens a frame
                    if (!ps2_data_r) begin
                        state_next = DATA;
                    end
                end
                DATA: begin
                    if (bit_cnt_r == 3'd7) begin
                        state_next = PARITY;
                    end
                end
                PARITY: begin
                    state_next = parity_ok ? STOP : IDLE;
                end
                STOP: begin
                    state_next = IDLE;
                end
                default: begin
                    state_next = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r   <= IDLE;
            bit_cnt_r <= 3'd0;
            parity_r  <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            state_r <= state_next;
            valid_o <= 1'b0;
            if (falling_edge) begin
                case (state_r)
                    IDLE: begin
                        bit_cnt_r <= 3'd0;
                        parity_r  <= 1'b0;
                    end
                    DATA: begin
                        bit_cnt_r <= bit_cnt_r + 3'd1;
                        parity_r  <= parity_r ^ ps2_data_r;
                    end
                    STOP: begin
                        // low stop bit drops the frame
                        valid_o <= ps2_data_r;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // payload path, lsb arrives first
    always_ff @(posedge clk_i) begin
        if (falling_edge && state_r == DATA) begin
            shift_r <= {ps2_data_r, shift_r[7:1]};
        end
        if (falling_edge && state_r == STOP) begin
            data_o <= shift_r;
        end
    end

endmodule

`default_nettype wire

// ==== design/common.sv ====
`default_nettype none

package common;

    // one scan-code byte as it comes off the wire
    typedef logic [7:0] byte_t;

    // one key action after prefix folding
    typedef struct packed {
        logic  extended;
        logic  released;
        byte_t code;
    } key_event_t;

    // set 2 prefix bytes
    localparam byte_t PREFIX_EXTENDED = 8'hE0;
    localparam byte_t PREFIX_RELEASE  = 8'hF0;

    // event queue size, a power of two so the pointers wrap on their own
    localparam int EVENT_FIFO_DEPTH = 8;
    localparam int EVENT_FIFO_PTR_W = $clog2(EVENT_FIFO_DEPTH);

endpackage

`default_nettype wire
